// ==== include/mem_unit_cfg.svh ====
`ifndef MEM_UNIT_CFG_SVH
`define MEM_UNIT_CFG_SVH

// Region sizes in 32-bit words.
`define MEM_SIZE    256
`define SHMEM_SIZE  256

// Threads per warp.
`define LANES       8

// Direct-mapped tag store geometry.
`define LINE_WORDS  8
`define CACHE_LINES 4

// Width of one latency table entry.
`define LAT_W       5

`endif

// ==== design/mem_unit_pkg.sv ====
`include "mem_unit_cfg.svh"

package mem_unit_pkg;

	localparam int WORD_W     = 32;
	localparam int MEM_AW     = $clog2(`MEM_SIZE);
	localparam int DBG_AW     = $clog2(`MEM_SIZE + `SHMEM_SIZE);
	localparam int LINE_SHIFT = $clog2(`LINE_WORDS);
	localparam int LINE_AW    = MEM_AW - LINE_SHIFT;
	localparam int IDX_W      = $clog2(`CACHE_LINES);

	typedef logic [WORD_W-1:0]            word_t;
	typedef logic [`LANES*WORD_W-1:0]     warp_data_t;
	typedef logic [`LANES-1:0]            lane_mask_t;
	typedef logic [2:0]                   warp_id_t;
	typedef logic [1:0]                   scb_id_t;
	typedef logic [4:0]                   reg_addr_t;
	typedef logic [31:0]                  instr_t;
	typedef logic [15:0]                  offset_t;
	typedef logic [MEM_AW-1:0]            mem_addr_t;

	// Global words sit below MEM_SIZE, shared words above.
	typedef logic [DBG_AW-1:0]            dbg_addr_t;
	typedef logic [LINE_AW-1:0]           line_addr_t;
	typedef logic [`LAT_W-1:0]            latency_t;
	typedef logic [`LANES*MEM_AW-1:0]     warp_addr_t;

endpackage

// ==== design/mem_addr_gen.sv ====
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module mem_addr_gen import mem_unit_pkg::*;
(
	input  warp_data_t rs_data_i,
	input  offset_t    offset_i,
	input  lane_mask_t pam_i,
	input  logic       mem_read_i,
	input  logic       mem_write_i,
	output warp_addr_t lane_addr_o,
	output warp_addr_t line_hit_addr_o,
	output lane_mask_t act_mask_o
);

	localparam int OFF_W = $bits(offset_t);

	word_t offset_ext;

	assign offset_ext = {{(WORD_W-OFF_W){offset_i[OFF_W-1]}}, offset_i};

	// Lanes are idle unless an access is actually issued.
	assign act_mask_o = (mem_read_i || mem_write_i) ? pam_i : '0;

	genvar l;
	generate
		for (l = 0; l < `LANES; l++)
		begin : g_lane
			word_t     eff;
			mem_addr_t wrapped;

			assign eff     = rs_data_i[l*WORD_W +: WORD_W] + offset_ext;

			// Both regions are a power of two in size, so the wrap is a plain truncation.
			assign wrapped = eff[MEM_AW-1:0];

			assign lane_addr_o[l*MEM_AW +: MEM_AW] = wrapped;

			// Word-in-line bits cleared for the tag lookup.
			assign line_hit_addr_o[l*MEM_AW +: MEM_AW] =
				{wrapped[MEM_AW-1:LINE_SHIFT], {LINE_SHIFT{1'b0}}};
		end
	endgenerate

endmodule

// ==== design/mem_tag_check.sv ====
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module mem_tag_check import mem_unit_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       mem_read_i,
	input  logic       mem_write_i,
	input  logic       shared_i,
	input  warp_addr_t lane_addr_i,
	input  warp_addr_t line_hit_addr_i,
	input  lane_mask_t act_mask_i,
	input  warp_id_t   warp_id_i,
	input  scb_id_t    scb_id_i,
	input  reg_addr_t  reg_addr_i,
	input  instr_t     instr_i,
	input  warp_data_t wdata_i,

	input  logic       lat_wen_i,
	input  line_addr_t lat_addr_i,
	input  latency_t   lat_din_i,
	output latency_t   lat_dout_o,

	output logic       mem_read_o,
	output logic       mem_write_o,
	output logic       shared_o,
	output warp_addr_t lane_addr_o,
	output lane_mask_t act_mask_o,
	output warp_id_t   warp_id_o,
	output scb_id_t    scb_id_o,
	output reg_addr_t  reg_addr_o,
	output instr_t     instr_o,
	output warp_data_t wdata_o,

	output logic       neg_fb_valid_o,
	output warp_id_t   neg_fb_warp_id_o,
	output scb_id_t    neg_fb_scb_id_o
);

	localparam int NUM_LINES = 2 ** LINE_AW;

	typedef enum logic {st_idle, st_filling} fill_state_t;

	fill_state_t state;
	latency_t    fill_cnt;
	line_addr_t  fill_line;
	logic        fill_start;
	logic        fill_done;

	logic [`CACHE_LINES-1:0] tag_valid;
	line_addr_t tag_line [`CACHE_LINES];
	latency_t   lat_table [NUM_LINES];

	line_addr_t lane_line [`LANES];
	lane_mask_t lane_present;
	logic       miss;
	line_addr_t miss_line;
	latency_t   miss_lat;

	always_comb
	begin
		lane_present = '0;
		miss_line    = '0;
		for (int l = 0; l < `LANES; l++)
		begin
			lane_line[l]    = line_hit_addr_i[l*MEM_AW+LINE_SHIFT +: LINE_AW];
			lane_present[l] = tag_valid[lane_line[l][IDX_W-1:0]] &&
				(tag_line[lane_line[l][IDX_W-1:0]] == lane_line[l]);
		end
		// Scan downward so the lowest absent lane wins.
		for (int l = `LANES-1; l >= 0; l--)
		begin
			if (act_mask_i[l] && !lane_present[l])
				miss_line = lane_line[l];
		end
	end

	assign miss       = mem_read_i && !shared_i && ((act_mask_i & ~lane_present) != '0);
	assign miss_lat   = lat_table[miss_line];
	assign fill_start = miss && (state == st_idle);
	assign fill_done  = (state == st_filling) && (fill_cnt == latency_t'(1));
	assign lat_dout_o = lat_table[lat_addr_i];

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < NUM_LINES; i++)
				lat_table[i] <= '0;
		end
		else if (lat_wen_i)
			lat_table[lat_addr_i] <= lat_din_i;
	end

	// Single fill in flight. A zero entry counts as one cycle.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state     <= st_idle;
			fill_cnt  <= '0;
			tag_valid <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (fill_start)
					begin
						state    <= st_filling;
						fill_cnt <= (miss_lat == '0) ? latency_t'(1) : miss_lat;
					end
				end
				st_filling:
				begin
					fill_cnt <= fill_cnt - latency_t'(1);
					if (fill_done)
					begin
						state                            <= st_idle;
						tag_valid[fill_line[IDX_W-1:0]] <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_start)
			fill_line <= miss_line;
		if (fill_done)
			tag_line[fill_line[IDX_W-1:0]] <= fill_line;
	end

	// A missed load is dropped here and only shows up as negative feedback.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			mem_read_o     <= 1'b0;
			mem_write_o    <= 1'b0;
			neg_fb_valid_o <= 1'b0;
		end
		else
		begin
			mem_read_o     <= mem_read_i && !miss;
			mem_write_o    <= mem_write_i;
			neg_fb_valid_o <= miss;
		end
	end

	always_ff @(posedge clk)
	begin
		shared_o    <= shared_i;
		lane_addr_o <= lane_addr_i;
		act_mask_o  <= act_mask_i;
		warp_id_o   <= warp_id_i;
		scb_id_o    <= scb_id_i;
		reg_addr_o  <= reg_addr_i;
		instr_o     <= instr_i;
		wdata_o     <= wdata_i;
	end

	assign neg_fb_warp_id_o = warp_id_o;
	assign neg_fb_scb_id_o  = scb_id_o;

endmodule

// ==== design/mem_data_array.sv ====
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module mem_data_array import mem_unit_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       mem_read_i,
	input  logic       mem_write_i,
	input  logic       shared_i,
	input  warp_addr_t lane_addr_i,
	input  lane_mask_t act_mask_i,
	input  warp_id_t   warp_id_i,
	input  scb_id_t    scb_id_i,
	input  reg_addr_t  reg_addr_i,
	input  instr_t     instr_i,
	input  warp_data_t wdata_i,

	input  logic       dbg_wen_i,
	input  dbg_addr_t  dbg_addr_i,
	input  word_t      dbg_din_i,
	output word_t      dbg_dout_o,

	output logic       pos_fb_valid_o,
	output warp_id_t   pos_fb_warp_id_o,
	output scb_id_t    pos_fb_scb_id_o,
	output lane_mask_t pos_fb_mask_o,
	output logic       cdb_reg_write_o,
	output reg_addr_t  cdb_reg_addr_o,
	output lane_mask_t cdb_mask_o,
	output warp_data_t cdb_data_o,
	output instr_t     cdb_instr_o
);

	word_t      shmem [`SHMEM_SIZE];
	word_t      gmem [`MEM_SIZE];
	warp_data_t rdata;
	lane_mask_t done_mask;
	logic       dbg_shared;
	mem_addr_t  dbg_word;

	assign dbg_shared = (dbg_addr_i >= dbg_addr_t'(`MEM_SIZE));
	assign dbg_word   = dbg_addr_i[MEM_AW-1:0];
	assign dbg_dout_o = dbg_shared ? shmem[dbg_word] : gmem[dbg_word];

	// Inactive lanes return zero.
	always_comb
	begin
		for (int l = 0; l < `LANES; l++)
		begin
			if (!act_mask_i[l])
				rdata[l*WORD_W +: WORD_W] = '0;
			else if (shared_i)
				rdata[l*WORD_W +: WORD_W] = shmem[lane_addr_i[l*MEM_AW +: MEM_AW]];
			else
				rdata[l*WORD_W +: WORD_W] = gmem[lane_addr_i[l*MEM_AW +: MEM_AW]];
		end
	end

	// When lanes collide on one address, the highest lane wins.
	always_ff @(posedge clk)
	begin
		if (mem_write_i)
		begin
			for (int l = 0; l < `LANES; l++)
			begin
				if (act_mask_i[l] && shared_i)
					shmem[lane_addr_i[l*MEM_AW +: MEM_AW]] <= wdata_i[l*WORD_W +: WORD_W];
				else if (act_mask_i[l])
					gmem[lane_addr_i[l*MEM_AW +: MEM_AW]] <= wdata_i[l*WORD_W +: WORD_W];
			end
		end
		if (dbg_wen_i && dbg_shared)
			shmem[dbg_word] <= dbg_din_i;
		else if (dbg_wen_i)
			gmem[dbg_word] <= dbg_din_i;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			pos_fb_valid_o  <= 1'b0;
			cdb_reg_write_o <= 1'b0;
		end
		else
		begin
			pos_fb_valid_o  <= mem_read_i || mem_write_i;
			cdb_reg_write_o <= mem_read_i;
		end
	end

	always_ff @(posedge clk)
	begin
		pos_fb_warp_id_o <= warp_id_i;
		pos_fb_scb_id_o  <= scb_id_i;
		done_mask        <= act_mask_i;
		cdb_reg_addr_o   <= reg_addr_i;
		cdb_data_o       <= rdata;
		cdb_instr_o      <= instr_i;
	end

	// Scoreboard and CDB see the same lane mask.
	assign pos_fb_mask_o = done_mask;
	assign cdb_mask_o    = done_mask;

endmodule

// ==== design/mem_unit.sv ====
`timescale 1ns/1ns

module mem_unit import mem_unit_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  logic       instr_valid_i,
	input  logic       mem_read_i,
	input  logic       mem_write_i,
	input  logic       shared_i,
	input  lane_mask_t pam_i,
	input  warp_id_t   warp_id_i,
	input  scb_id_t    scb_id_i,
	input  warp_data_t rs_data_i,
	input  warp_data_t rt_data_i,
	input  offset_t    offset_i,
	input  reg_addr_t  reg_addr_i,
	input  instr_t     instr_i,

	input  logic       dbg_wen_i,
	input  dbg_addr_t  dbg_addr_i,
	input  word_t      dbg_din_i,
	output word_t      dbg_dout_o,

	input  logic       lat_wen_i,
	input  line_addr_t lat_addr_i,
	input  latency_t   lat_din_i,
	output latency_t   lat_dout_o,

	output logic       pos_fb_valid_o,
	output warp_id_t   pos_fb_warp_id_o,
	output scb_id_t    pos_fb_scb_id_o,
	output lane_mask_t pos_fb_mask_o,
	output logic       neg_fb_valid_o,
	output warp_id_t   neg_fb_warp_id_o,
	output scb_id_t    neg_fb_scb_id_o,
	output logic       cdb_reg_write_o,
	output reg_addr_t  cdb_reg_addr_o,
	output lane_mask_t cdb_mask_o,
	output warp_data_t cdb_data_o,
	output instr_t     cdb_instr_o
);

	logic       read_q;
	logic       write_q;
	logic       shared_q;
	lane_mask_t pam_q;
	warp_id_t   warp_id_q;
	scb_id_t    scb_id_q;
	warp_data_t rs_data_q;
	warp_data_t rt_data_q;
	offset_t    offset_q;
	reg_addr_t  reg_addr_q;
	instr_t     instr_q;

	warp_addr_t s1_lane_addr;
	warp_addr_t s1_line_addr;
	lane_mask_t s1_act_mask;

	logic       s3_read;
	logic       s3_write;
	logic       s3_shared;
	warp_addr_t s3_lane_addr;
	lane_mask_t s3_act_mask;
	warp_id_t   s3_warp_id;
	scb_id_t    s3_scb_id;
	reg_addr_t  s3_reg_addr;
	instr_t     s3_instr;
	warp_data_t s3_wdata;

	// The request payload is held while no new request arrives.
	always_ff @(posedge clk)
	begin
		if (instr_valid_i)
		begin
			shared_q   <= shared_i;
			pam_q      <= pam_i;
			warp_id_q  <= warp_id_i;
			scb_id_q   <= scb_id_i;
			rs_data_q  <= rs_data_i;
			rt_data_q  <= rt_data_i;
			offset_q   <= offset_i;
			reg_addr_q <= reg_addr_i;
			instr_q    <= instr_i;
		end
	end

	// Strobes last one cycle per request.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			read_q  <= 1'b0;
			write_q <= 1'b0;
		end
		else
		begin
			read_q  <= instr_valid_i && mem_read_i;
			write_q <= instr_valid_i && mem_write_i;
		end
	end

	mem_addr_gen addr_gen0 (
		.rs_data_i       (rs_data_q),
		.offset_i        (offset_q),
		.pam_i           (pam_q),
		.mem_read_i      (read_q),
		.mem_write_i     (write_q),
		.lane_addr_o     (s1_lane_addr),
		.line_hit_addr_o (s1_line_addr),
		.act_mask_o      (s1_act_mask)
	);

	mem_tag_check tag_check0 (
		.clk              (clk),
		.rst              (rst),
		.mem_read_i       (read_q),
		.mem_write_i      (write_q),
		.shared_i         (shared_q),
		.lane_addr_i      (s1_lane_addr),
		.line_hit_addr_i  (s1_line_addr),
		.act_mask_i       (s1_act_mask),
		.warp_id_i        (warp_id_q),
		.scb_id_i         (scb_id_q),
		.reg_addr_i       (reg_addr_q),
		.instr_i          (instr_q),
		.wdata_i          (rt_data_q),
		.lat_wen_i        (lat_wen_i),
		.lat_addr_i       (lat_addr_i),
		.lat_din_i        (lat_din_i),
		.lat_dout_o       (lat_dout_o),
		.mem_read_o       (s3_read),
		.mem_write_o      (s3_write),
		.shared_o         (s3_shared),
		.lane_addr_o      (s3_lane_addr),
		.act_mask_o       (s3_act_mask),
		.warp_id_o        (s3_warp_id),
		.scb_id_o         (s3_scb_id),
		.reg_addr_o       (s3_reg_addr),
		.instr_o          (s3_instr),
		.wdata_o          (s3_wdata),
		.neg_fb_valid_o   (neg_fb_valid_o),
		.neg_fb_warp_id_o (neg_fb_warp_id_o),
		.neg_fb_scb_id_o  (neg_fb_scb_id_o)
	);

	mem_data_array data_array0 (
		.clk              (clk),
		.rst              (rst),
		.mem_read_i       (s3_read),
		.mem_write_i      (s3_write),
		.shared_i         (s3_shared),
		.lane_addr_i      (s3_lane_addr),
		.act_mask_i       (s3_act_mask),
		.warp_id_i        (s3_warp_id),
		.scb_id_i         (s3_scb_id),
		.reg_addr_i       (s3_reg_addr),
		.instr_i          (s3_instr),
		.wdata_i          (s3_wdata),
		.dbg_wen_i        (dbg_wen_i),
		.dbg_addr_i       (dbg_addr_i),
		.dbg_din_i        (dbg_din_i),
		.dbg_dout_o       (dbg_dout_o),
		.pos_fb_valid_o   (pos_fb_valid_o),
		.pos_fb_warp_id_o (pos_fb_warp_id_o),
		.pos_fb_scb_id_o  (pos_fb_scb_id_o),
		.pos_fb_mask_o    (pos_fb_mask_o),
		.cdb_reg_write_o  (cdb_reg_write_o),
		.cdb_reg_addr_o   (cdb_reg_addr_o),
		.cdb_mask_o       (cdb_mask_o),
		.cdb_data_o       (cdb_data_o),
		.cdb_instr_o      (cdb_instr_o)
	);

endmodule

// ==== verification/mem_unit_props.sv ====
`timescale 1ns/1ns

module mem_unit_props
(
	input logic clk,
	input logic rst,
	input logic instr_valid_i,
	input logic mem_read_i,
	input logic shared_i,
	input logic pos_fb_valid_o,
	input logic neg_fb_valid_o,
	input logic cdb_reg_write_o
);

	int fail_cnt = 0;

	// A CDB write is always part of a completion.
	cdb_needs_pos: assert property (@(posedge clk) disable iff (!rst)
		cdb_reg_write_o |-> pos_fb_valid_o)
		else
		begin
			$error("cdb_reg_write_o raised without pos_fb_valid_o");
			fail_cnt++;
		end

	// Only a global load can miss, two edges after it was sampled.
	neg_from_global_load: assert property (@(posedge clk) disable iff (!rst)
		neg_fb_valid_o |-> $past(instr_valid_i && mem_read_i && !shared_i, 2))
		else
		begin
			$error("neg_fb_valid_o without a global load two edges earlier");
			fail_cnt++;
		end

	quiet_in_reset: assert property (@(posedge clk)
		!rst |=> (!pos_fb_valid_o && !neg_fb_valid_o && !cdb_reg_write_o))
		else
		begin
			$error("Output strobe high during reset");
			fail_cnt++;
		end

endmodule

bind mem_unit mem_unit_props props0 (.*);

// ==== verification/mem_unit_tb.sv ====
`timescale 1ns/1ns
`include "mem_unit_cfg.svh"

module mem_unit_tb import mem_unit_pkg::*;
();

	localparam int TIMEOUT = 8;
	localparam int NUM_LN  = 2 ** LINE_AW;

	logic       clk;
	logic       rst;
	logic       instr_valid_i;
	logic       mem_read_i;
	logic       mem_write_i;
	logic       shared_i;
	lane_mask_t pam_i;
	warp_id_t   warp_id_i;
	scb_id_t    scb_id_i;
	warp_data_t rs_data_i;
	warp_data_t rt_data_i;
	offset_t    offset_i;
	reg_addr_t  reg_addr_i;
	instr_t     instr_i;
	logic       dbg_wen_i;
	dbg_addr_t  dbg_addr_i;
	word_t      dbg_din_i;
	word_t      dbg_dout_o;
	logic       lat_wen_i;
	line_addr_t lat_addr_i;
	latency_t   lat_din_i;
	latency_t   lat_dout_o;
	logic       pos_fb_valid_o;
	warp_id_t   pos_fb_warp_id_o;
	scb_id_t    pos_fb_scb_id_o;
	lane_mask_t pos_fb_mask_o;
	logic       neg_fb_valid_o;
	warp_id_t   neg_fb_warp_id_o;
	scb_id_t    neg_fb_scb_id_o;
	logic       cdb_reg_write_o;
	reg_addr_t  cdb_reg_addr_o;
	lane_mask_t cdb_mask_o;
	warp_data_t cdb_data_o;
	instr_t     cdb_instr_o;

	// Reference model with shadow memories, tag store and the single fill.
	word_t       gm [`MEM_SIZE];
	word_t       sm [`SHMEM_SIZE];
	logic        tv [`CACHE_LINES];
	line_addr_t  tl [`CACHE_LINES];
	latency_t    lat_m [NUM_LN];
	logic        fill_busy;
	int          fill_until;
	line_addr_t  fill_ln;
	line_addr_t  pick_ln [4];
	logic [31:0] rng;
	int          cyc = 0;
	int          errors;
	int          tests;
	int          failed;
	int          test_err0;

	// Request slots. Slot 1 is only used for back-to-back issue.
	logic       q_read [2];
	logic       q_shared [2];
	lane_mask_t q_pam [2];
	warp_id_t   q_warp [2];
	scb_id_t    q_scb [2];
	warp_data_t q_rs [2];
	warp_data_t q_rt [2];
	offset_t    q_off [2];
	reg_addr_t  q_reg [2];
	instr_t     q_instr [2];
	warp_data_t q_exp [2];
	logic       q_hit [2];

	mem_unit dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic word_t sext_off(int k);
		return {{16{q_off[k][15]}}, q_off[k]};
	endfunction

	// Effective word address wrapped to the 256-word region.
	function automatic mem_addr_t lane_addr(int k, int l);
		word_t sum;
		sum = q_rs[k][l*32 +: 32] + sext_off(k);
		return mem_addr_t'(sum);
	endfunction

	task automatic compare_data(string name, warp_data_t got, warp_data_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t ns %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_mask(string name, lane_mask_t got, lane_mask_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t ns %s: got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_id(string name, warp_id_t gw, scb_id_t gs, warp_id_t ew, scb_id_t es);
		if (gw !== ew || gs !== es)
		begin
			$display("ERROR %0t ns %s: got warp %0d scb %0d expected warp %0d scb %0d",
				$time, name, gw, gs, ew, es);
			errors++;
		end
	endtask

	task automatic compare_word(string name, word_t got, word_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t ns %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_lat(string name, latency_t got, latency_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t ns %s: got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_reg(string name, reg_addr_t got, reg_addr_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t ns %s: got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("ERROR %0t ns %s: got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_edge(string name, int got, int exp);
		if (got != exp)
		begin
			$display("ERROR %0t ns %s: got edge %0d expected edge %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic make_req(int k, logic rd, logic sh);
		q_read[k]   = rd;
		q_shared[k] = sh;
		q_pam[k]    = lane_mask_t'(next_rand());
		q_warp[k]   = warp_id_t'(next_rand());
		q_scb[k]    = scb_id_t'(next_rand());
		q_off[k]    = offset_t'(next_rand());
		q_reg[k]    = reg_addr_t'(next_rand());
		q_instr[k]  = next_rand();
		for (int l = 0; l < `LANES; l++)
		begin
			q_rs[k][l*32 +: 32] = next_rand();
			q_rt[k][l*32 +: 32] = next_rand();
		end
	endtask

	// Points every lane at a random word of one of the first n picked lines.
	task automatic aim_lanes(int k, int n);
		mem_addr_t target;
		for (int l = 0; l < `LANES; l++)
		begin
			target = mem_addr_t'(pick_ln[next_rand() % n] * `LINE_WORDS +
				next_rand() % `LINE_WORDS);
			q_rs[k][l*32 +: 32] = (next_rand() << 8) + word_t'(target) - sext_off(k);
		end
	endtask

	task automatic drive_slot(int k);
		instr_valid_i = 1'b1;
		mem_read_i    = q_read[k];
		mem_write_i   = !q_read[k];
		shared_i      = q_shared[k];
		pam_i         = q_pam[k];
		warp_id_i     = q_warp[k];
		scb_id_i      = q_scb[k];
		rs_data_i     = q_rs[k];
		rt_data_i     = q_rt[k];
		offset_i      = q_off[k];
		reg_addr_i    = q_reg[k];
		instr_i       = q_instr[k];
	endtask

	// Updates the model for a request sampled on edge c.
	task automatic predict(int k, int c);
		lane_mask_t absent;
		line_addr_t ln;
		line_addr_t miss_ln;
		latency_t   lat;
		mem_addr_t  a;
		int         idx;
		if (fill_busy && c >= fill_until)
		begin
			tv[fill_ln % `CACHE_LINES] = 1'b1;
			tl[fill_ln % `CACHE_LINES] = fill_ln;
			fill_busy = 1'b0;
		end
		absent  = '0;
		miss_ln = '0;
		for (int l = `LANES - 1; l >= 0; l--)
		begin
			a   = lane_addr(k, l);
			ln  = line_addr_t'(a / `LINE_WORDS);
			idx = ln % `CACHE_LINES;
			if (!q_pam[k][l])
				q_exp[k][l*32 +: 32] = '0;
			else if (q_shared[k])
				q_exp[k][l*32 +: 32] = sm[a];
			else
				q_exp[k][l*32 +: 32] = gm[a];
			if (q_pam[k][l] && !(tv[idx] && tl[idx] == ln))
			begin
				absent[l] = 1'b1;
				miss_ln   = ln;
			end
		end
		q_hit[k] = !(q_read[k] && !q_shared[k] && absent != '0);
		if (!q_hit[k] && !fill_busy)
		begin
			lat        = lat_m[miss_ln];
			fill_busy  = 1'b1;
			fill_ln    = miss_ln;
			fill_until = c + 1 + ((lat == 0) ? 1 : int'(lat));
		end
		for (int l = 0; l < `LANES; l++)
		begin
			if (!q_read[k] && q_pam[k][l] && q_shared[k])
				sm[lane_addr(k, l)] = q_rt[k][l*32 +: 32];
			else if (!q_read[k] && q_pam[k][l])
				gm[lane_addr(k, l)] = q_rt[k][l*32 +: 32];
		end
	endtask

	task automatic check_completion(int k);
		compare_id("pos_fb ids", pos_fb_warp_id_o, pos_fb_scb_id_o, q_warp[k], q_scb[k]);
		compare_mask("pos_fb_mask_o", pos_fb_mask_o, q_pam[k]);
		compare_bit("cdb_reg_write_o", cdb_reg_write_o, q_read[k]);
		if (q_read[k])
		begin
			compare_reg("cdb_reg_addr_o", cdb_reg_addr_o, q_reg[k]);
			compare_mask("cdb_mask_o", cdb_mask_o, q_pam[k]);
			compare_data("cdb_data_o", cdb_data_o, q_exp[k]);
			compare_word("cdb_instr_o", cdb_instr_o, q_instr[k]);
		end
	endtask

	// Issues slot 0 sampled no earlier than edge at, then checks its outcome.
	task automatic run_req(input int at, output logic got_neg);
		int n;
		int guard;
		int pos_n;
		int neg_n;
		guard = 0;
		@(posedge clk);
		#2;
		while (cyc + 1 < at && guard < 200)
		begin
			@(posedge clk);
			#2;
			guard++;
		end
		if (cyc + 1 < at)
		begin
			$display("Issue edge %0d was never reached", at);
			errors++;
		end
		drive_slot(0);
		predict(0, cyc + 1);
		@(posedge clk);
		#2;
		instr_valid_i = 1'b0;
		n     = 0;
		pos_n = 0;
		neg_n = 0;
		while (pos_n == 0 && neg_n == 0 && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
			if (pos_fb_valid_o)
				pos_n = n;
			if (neg_fb_valid_o)
				neg_n = n;
		end
		got_neg = (neg_n != 0);
		if (pos_n == 0 && neg_n == 0)
		begin
			$display("Request from warp %0d got no completion and no negative feedback",
				q_warp[0]);
			errors++;
		end
		else if (neg_n != 0)
		begin
			compare_bit("hit", 1'b0, q_hit[0]);
			compare_edge("neg_fb_valid_o", neg_n, 2);
			compare_id("neg_fb ids", neg_fb_warp_id_o, neg_fb_scb_id_o, q_warp[0], q_scb[0]);
			@(negedge clk);
			compare_bit("pos_fb_valid_o after miss", pos_fb_valid_o, 1'b0);
		end
		else
		begin
			compare_bit("hit", 1'b1, q_hit[0]);
			compare_edge("pos_fb_valid_o", pos_n, 3);
			check_completion(0);
		end
	endtask

	task automatic replay_until_hit();
		logic neg;
		int   tries;
		tries = 0;
		run_req(0, neg);
		while (neg && tries < 8)
		begin
			// Replay on the edge where the pending line becomes visible.
			run_req(fill_busy ? fill_until : 0, neg);
			tries++;
		end
		if (neg)
		begin
			$display("Load from warp %0d was still rejected after %0d replays", q_warp[0], tries);
			errors++;
		end
	endtask

	task automatic lat_write(line_addr_t a, latency_t v);
		@(posedge clk);
		#2;
		lat_wen_i  = 1'b1;
		lat_addr_i = a;
		lat_din_i  = v;
		lat_m[a]   = v;
		@(posedge clk);
		#2;
		lat_wen_i  = 1'b0;
	endtask

	task automatic preload();
		word_t d;
		for (int a = 0; a < `MEM_SIZE + `SHMEM_SIZE; a++)
		begin
			d = 32'hC0DE0000 ^ (a * 32'h00010003);
			@(posedge clk);
			#2;
			dbg_wen_i  = 1'b1;
			dbg_addr_i = dbg_addr_t'(a);
			dbg_din_i  = d;
			if (a < `MEM_SIZE)
				gm[a] = d;
			else
				sm[a - `MEM_SIZE] = d;
		end
		@(posedge clk);
		#2;
		dbg_wen_i = 1'b0;
		for (int i = 0; i < NUM_LN; i++)
			lat_write(line_addr_t'(i), latency_t'(next_rand() % 8));
	endtask

	task automatic check_memories();
		for (int a = 0; a < `MEM_SIZE + `SHMEM_SIZE; a++)
		begin
			@(posedge clk);
			#2;
			dbg_addr_i = dbg_addr_t'(a);
			@(negedge clk);
			compare_word($sformatf("dbg_dout_o[%0d]", a), dbg_dout_o,
				(a < `MEM_SIZE) ? gm[a] : sm[a - `MEM_SIZE]);
		end
	endtask

	task automatic end_test(string name);
		tests++;
		if (errors != test_err0)
		begin
			failed++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_err0);
		end
		else
			$display("test %0d %s: ok", tests, name);
		test_err0 = errors;
	endtask

	task automatic back_to_back_shared();
		int   n;
		logic seen;
		make_req(0, 1'b1, 1'b1);
		make_req(1, 1'b1, 1'b1);
		@(posedge clk);
		#2;
		drive_slot(0);
		predict(0, cyc + 1);
		@(posedge clk);
		#2;
		drive_slot(1);
		predict(1, cyc + 1);
		@(posedge clk);
		#2;
		instr_valid_i = 1'b0;
		n    = 1;
		seen = 1'b0;
		while (!seen && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
			seen = pos_fb_valid_o;
		end
		if (!seen)
		begin
			$display("Back-to-back shared loads never completed");
			errors++;
		end
		else
		begin
			compare_edge("first pos_fb_valid_o", n, 3);
			check_completion(0);
			@(negedge clk);
			compare_bit("second pos_fb_valid_o", pos_fb_valid_o, 1'b1);
			check_completion(1);
		end
	endtask

	initial
	begin
		#2_000_000;
		$display("Simulation time limit reached");
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		logic       neg;
		line_addr_t x;
		latency_t   lat;
		instr_valid_i = 1'b0;
		mem_read_i    = 1'b0;
		mem_write_i   = 1'b0;
		shared_i      = 1'b0;
		pam_i         = '0;
		warp_id_i     = '0;
		scb_id_i      = '0;
		rs_data_i     = '0;
		rt_data_i     = '0;
		offset_i      = '0;
		reg_addr_i    = '0;
		instr_i       = '0;
		dbg_wen_i     = 1'b0;
		dbg_addr_i    = '0;
		dbg_din_i     = '0;
		lat_wen_i     = 1'b0;
		lat_addr_i    = '0;
		lat_din_i     = '0;
		rng           = 32'd75173;
		errors        = 0;
		tests         = 0;
		failed        = 0;
		test_err0     = 0;
		fill_busy     = 1'b0;
		fill_until    = 0;
		fill_ln       = '0;
		for (int i = 0; i < `CACHE_LINES; i++)
		begin
			tv[i] = 1'b0;
			tl[i] = '0;
		end
		for (int i = 0; i < NUM_LN; i++)
			lat_m[i] = '0;
		rst = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b1;
		preload();

		for (int i = 0; i < 16; i++)
		begin
			make_req(0, 1'b0, 1'b1);
			run_req(0, neg);
			q_read[0] = 1'b1;
			q_pam[0]  = lane_mask_t'(next_rand());
			q_warp[0] = warp_id_t'(next_rand());
			q_scb[0]  = scb_id_t'(next_rand());
			run_req(0, neg);
		end
		end_test("shared store and load");

		for (int i = 0; i < 12; i++)
		begin
			make_req(0, 1'b0, 1'b0);
			run_req(0, neg);
		end
		check_memories();
		// All tags are still cold, so this load has to miss.
		q_read[0] = 1'b1;
		q_pam[0]  = '1;
		run_req(0, neg);
		compare_bit("neg_fb_valid_o after global stores", neg, 1'b1);
		end_test("global store");

		for (int i = 0; i < 8; i++)
		begin
			for (int j = 0; j < 4; j++)
				pick_ln[j] = line_addr_t'((next_rand() % 8) * 4 + j);
			make_req(0, 1'b1, 1'b0);
			q_pam[0] = q_pam[0] | lane_mask_t'(1);
			aim_lanes(0, 1 + i % 4);
			replay_until_hit();
		end
		end_test("global load with fills");

		lat = latency_t'(4 + next_rand() % 20);
		x   = line_addr_t'(next_rand());
		for (int t = 0; t < 20 && tv[x % `CACHE_LINES] && tl[x % `CACHE_LINES] == x; t++)
			x = line_addr_t'(next_rand());
		lat_write(x, lat);
		lat_write(x ^ line_addr_t'(8), lat);
		lat_addr_i = x;
		#1;
		compare_lat("lat_dout_o", lat_dout_o, lat);
		pick_ln[0] = x;
		make_req(0, 1'b1, 1'b0);
		q_pam[0] = '1;
		aim_lanes(0, 1);
		run_req(0, neg);
		run_req(fill_until - 1, neg);
		compare_bit("neg_fb_valid_o one edge early", neg, 1'b1);
		// Same index, so this line is absent once x is installed.
		pick_ln[0] = x ^ line_addr_t'(8);
		aim_lanes(0, 1);
		run_req(0, neg);
		run_req(fill_until, neg);
		compare_bit("neg_fb_valid_o on the exposure edge", neg, 1'b0);
		end_test("fill exposure");

		x = line_addr_t'(next_rand());
		pick_ln[0] = x;
		make_req(0, 1'b1, 1'b0);
		q_pam[0] = '1;
		aim_lanes(0, 1);
		replay_until_hit();
		pick_ln[0] = x ^ line_addr_t'(4);
		aim_lanes(0, 1);
		replay_until_hit();
		pick_ln[0] = x;
		aim_lanes(0, 1);
		run_req(0, neg);
		compare_bit("neg_fb_valid_o after eviction", neg, 1'b1);
		back_to_back_shared();
		end_test("eviction and back-to-back");

		errors = errors + dut0.props0.fail_cnt;
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
design/mem_unit_pkg.sv
design/mem_addr_gen.sv
design/mem_tag_check.sv
design/mem_data_array.sv
design/mem_unit.sv
verification/mem_unit_props.sv
verification/mem_unit_tb.sv
